// File: Bender.yml
package:
  name: mini_core

sources:
  - rtl/core_pkg.sv
  - rtl/stage_if.sv
  - rtl/ifu_stage.sv
  - rtl/id_stage.sv
  - rtl/regfile.sv
  - rtl/ex_stage.sv
  - rtl/lsu_stage.sv
  - rtl/core_top.sv
  - target: test
    files:
      - verification/core_tb.sv

// File: compile.f
rtl/core_pkg.sv
rtl/stage_if.sv
rtl/ifu_stage.sv
rtl/id_stage.sv
rtl/regfile.sv
rtl/ex_stage.sv
rtl/lsu_stage.sv
rtl/core_top.sv
verification/core_tb.sv

// File: rtl/core_pkg.sv
package core_pkg;

	localparam int XLEN = 32;
	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

	// major opcodes of the supported subset
	localparam logic [6:0] OP_OP     = 7'b0110011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASSB
	} alu_op_e;

	// same word, register layout or split store immediate
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r_view;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s_view;
	} inst_u;

	typedef struct packed {
		alu_op_e         alu_op;
		logic [XLEN-1:0] opa;
		logic [XLEN-1:0] opb;
		logic [XLEN-1:0] store_data;
		logic [4:0]      rd;
		logic            rd_wen;
		logic            is_load;
		logic            is_store;
		logic            is_halt;
	} id_ex_t;

	typedef struct packed {
		logic [XLEN-1:0] result;
		logic [XLEN-1:0] store_data;
		logic [4:0]      rd;
		logic            rd_wen;
		logic            is_load;
		logic            is_store;
		logic            is_halt;
	} ex_ls_t;

endpackage

// File: rtl/core_top.sv
module core_top (
	input  logic                      clock,
	input  logic                      rst_i,
	input  logic                      inst_pvalid_i,
	input  logic [core_pkg::XLEN-1:0] inst_prdata_i,
	output logic                      inst_psel_o,
	output logic [core_pkg::XLEN-1:0] inst_paddr_o,
	input  logic [core_pkg::XLEN-1:0] data_prdata_i,
	input  logic                      data_pvalid_i,
	output logic                      data_psel_o,
	output logic                      data_pwrite_o,
	output logic [core_pkg::XLEN-1:0] data_paddr_o,
	output logic [core_pkg::XLEN-1:0] data_pwdata_o,
	output logic [3:0]                data_pwstrb_o,
	output logic                      halt_o
);
	import core_pkg::*;

	logic            flush;
	logic [XLEN-1:0] flush_pc;
	logic [4:0]      rs1_addr;
	logic [4:0]      rs2_addr;
	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;
	logic [4:0]      ex_rd;
	logic            ex_wen;
	logic [4:0]      ls_rd;
	logic            ls_wen;
	logic            reg_wen;
	logic [4:0]      reg_waddr;
	logic [XLEN-1:0] reg_wdata;

	stage_if #(.payload_t(inst_u))  if_id ();
	stage_if #(.payload_t(id_ex_t)) id_ex ();
	stage_if #(.payload_t(ex_ls_t)) ex_ls ();

	ifu_stage u_ifu (
		.clock         (clock),
		.rst_i         (rst_i),
		.flush_i       (flush),
		.flush_pc_i    (flush_pc),
		.inst_pvalid_i (inst_pvalid_i),
		.inst_prdata_i (inst_prdata_i),
		.inst_psel_o   (inst_psel_o),
		.inst_paddr_o  (inst_paddr_o),
		.out           (if_id)
	);

	id_stage u_id (
		.clock      (clock),
		.rst_i      (rst_i),
		.rs1_data_i (rs1_data),
		.rs2_data_i (rs2_data),
		.ex_rd_i    (ex_rd),
		.ex_wen_i   (ex_wen),
		.ls_rd_i    (ls_rd),
		.ls_wen_i   (ls_wen),
		.rs1_addr_o (rs1_addr),
		.rs2_addr_o (rs2_addr),
		.flush_o    (flush),
		.flush_pc_o (flush_pc),
		.in         (if_id),
		.out        (id_ex)
	);

	regfile u_regfile (
		.clock    (clock),
		.rst_i    (rst_i),
		.raddr1_i (rs1_addr),
		.raddr2_i (rs2_addr),
		.wen_i    (reg_wen),
		.waddr_i  (reg_waddr),
		.wdata_i  (reg_wdata),
		.rdata1_o (rs1_data),
		.rdata2_o (rs2_data)
	);

	ex_stage u_ex (
		.clock (clock),
		.rst_i (rst_i),
		.rd_o  (ex_rd),
		.wen_o (ex_wen),
		.in    (id_ex),
		.out   (ex_ls)
	);

	lsu_stage u_lsu (
		.clock         (clock),
		.rst_i         (rst_i),
		.data_prdata_i (data_prdata_i),
		.data_pvalid_i (data_pvalid_i),
		.data_psel_o   (data_psel_o),
		.data_pwrite_o (data_pwrite_o),
		.data_paddr_o  (data_paddr_o),
		.data_pwdata_o (data_pwdata_o),
		.data_pwstrb_o (data_pwstrb_o),
		.rd_o          (ls_rd),
		.wen_o         (ls_wen),
		.reg_wen_o     (reg_wen),
		.reg_waddr_o   (reg_waddr),
		.reg_wdata_o   (reg_wdata),
		.halt_o        (halt_o),
		.in            (ex_ls)
	);

endmodule

// File: rtl/ex_stage.sv
module ex_stage (
	input  logic       clock,
	input  logic       rst_i,
	output logic [4:0] rd_o,
	output logic       wen_o,
	stage_if.down      in,
	stage_if.up        out
);
	import core_pkg::*;

	logic            valid_q;
	id_ex_t          op_q;
	logic [XLEN-1:0] pc_q;
	logic [XLEN-1:0] alu_res;
	ex_ls_t          res;

	assign in.allowin = ~valid_q | out.allowin;

	always_ff @(posedge clock) begin
		if (rst_i) begin
			valid_q <= 1'b0;
		end else if (in.allowin) begin
			valid_q <= in.valid;
		end
	end

	always_ff @(posedge clock) begin
		if (in.valid && in.allowin) begin
			op_q <= in.payload;
			pc_q <= in.pc;
		end
	end

	// loads and stores use ALU_ADD for the address
	always_comb begin
		case (op_q.alu_op)
			ALU_SUB:   alu_res = op_q.opa - op_q.opb;
			ALU_AND:   alu_res = op_q.opa & op_q.opb;
			ALU_OR:    alu_res = op_q.opa | op_q.opb;
			ALU_XOR:   alu_res = op_q.opa ^ op_q.opb;
			ALU_SLT:   alu_res = {31'd0, $signed(op_q.opa) < $signed(op_q.opb)};
			ALU_PASSB: alu_res = op_q.opb;
			default:   alu_res = op_q.opa + op_q.opb;
		endcase
	end

	always_comb begin
		res.result     = alu_res;
		res.store_data = op_q.store_data;
		res.rd         = op_q.rd;
		res.rd_wen     = op_q.rd_wen;
		res.is_load    = op_q.is_load;
		res.is_store   = op_q.is_store;
		res.is_halt    = op_q.is_halt;
	end

	assign out.valid   = valid_q;
	assign out.pc      = pc_q;
	assign out.payload = res;

	// occupant reported to the decode interlock
	assign rd_o  = op_q.rd;
	assign wen_o = valid_q & op_q.rd_wen;

endmodule

// File: rtl/id_stage.sv
module id_stage (
	input  logic                      clock,
	input  logic                      rst_i,
	input  logic [core_pkg::XLEN-1:0] rs1_data_i,
	input  logic [core_pkg::XLEN-1:0] rs2_data_i,
	input  logic [4:0]                ex_rd_i,
	input  logic                      ex_wen_i,
	input  logic [4:0]                ls_rd_i,
	input  logic                      ls_wen_i,
	output logic [4:0]                rs1_addr_o,
	output logic [4:0]                rs2_addr_o,
	output logic                      flush_o,
	output logic [core_pkg::XLEN-1:0] flush_pc_o,
	stage_if.down                     in,
	stage_if.up                       out
);
	import core_pkg::*;

	logic            valid_q;
	logic            halted_q;
	inst_u           inst_q;
	logic [XLEN-1:0] pc_q;
	logic [6:0]      opcode;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_j;
	logic [XLEN-1:0] imm_u;
	logic            use_rs1;
	logic            use_rs2;
	logic            stall;
	logic            taken;
	logic            fire;
	logic            in_fire;
	id_ex_t          dec;

	function automatic logic busy(input logic [4:0] r);
		busy = (r != 5'd0) & ((ex_wen_i & (ex_rd_i == r)) | (ls_wen_i & (ls_rd_i == r)));
	endfunction

	function automatic alu_op_e alu_sel(input logic [2:0] f3);
		case (f3)
			3'b010:  alu_sel = ALU_SLT;
			3'b100:  alu_sel = ALU_XOR;
			3'b110:  alu_sel = ALU_OR;
			3'b111:  alu_sel = ALU_AND;
			default: alu_sel = ALU_ADD;
		endcase
	endfunction

	assign opcode     = inst_q.r_view.opcode;
	assign rs1_addr_o = inst_q.r_view.rs1;
	assign rs2_addr_o = inst_q.r_view.rs2;

	// immediates rebuilt from the two views of the word
	assign imm_i = {{20{inst_q.r_view.funct7[6]}}, inst_q.r_view.funct7, inst_q.r_view.rs2};
	assign imm_s = {{20{inst_q.s_view.imm_hi[6]}}, inst_q.s_view.imm_hi, inst_q.s_view.imm_lo};
	assign imm_b = {{19{inst_q.s_view.imm_hi[6]}}, inst_q.s_view.imm_hi[6],
		inst_q.s_view.imm_lo[0], inst_q.s_view.imm_hi[5:0], inst_q.s_view.imm_lo[4:1], 1'b0};
	assign imm_u = {inst_q.r_view.funct7, inst_q.r_view.rs2, inst_q.r_view.rs1,
		inst_q.r_view.funct3, 12'd0};
	assign imm_j = {{11{inst_q.r_view.funct7[6]}}, inst_q.r_view.funct7[6], inst_q.r_view.rs1,
		inst_q.r_view.funct3, inst_q.r_view.rs2[0], inst_q.r_view.funct7[5:0],
		inst_q.r_view.rs2[4:1], 1'b0};

	assign use_rs1 = opcode inside {OP_OP, OP_IMM, OP_LOAD, OP_STORE, OP_BRANCH};
	assign use_rs2 = opcode inside {OP_OP, OP_STORE, OP_BRANCH};

	// interlock until the producer has written back
	always_comb begin
		stall = valid_q & ((use_rs1 & busy(inst_q.r_view.rs1)) |
			(use_rs2 & busy(inst_q.r_view.rs2)));
	end

	// funct3[0] picks bne over beq
	assign taken = (opcode == OP_JAL) |
		((opcode == OP_BRANCH) & ((rs1_data_i == rs2_data_i) ^ inst_q.r_view.funct3[0]));
	assign flush_pc_o = pc_q + ((opcode == OP_JAL) ? imm_j : imm_b);

	always_comb begin
		dec            = '0;
		dec.alu_op     = ALU_ADD;
		dec.opa        = rs1_data_i;
		dec.opb        = imm_i;
		dec.store_data = rs2_data_i;
		dec.rd         = inst_q.r_view.rd;
		case (opcode)
			OP_OP: begin
				dec.opb    = rs2_data_i;
				dec.rd_wen = 1'b1;
				if (inst_q.r_view.funct3 == 3'b000 && inst_q.r_view.funct7[5]) begin
					dec.alu_op = ALU_SUB;
				end else begin
					dec.alu_op = alu_sel(inst_q.r_view.funct3);
				end
			end
			OP_IMM: begin
				dec.alu_op = alu_sel(inst_q.r_view.funct3);
				dec.rd_wen = 1'b1;
			end
			OP_LUI: begin
				dec.alu_op = ALU_PASSB;
				dec.opb    = imm_u;
				dec.rd_wen = 1'b1;
			end
			OP_LOAD: begin
				dec.rd_wen  = 1'b1;
				dec.is_load = 1'b1;
			end
			OP_STORE: begin
				dec.opb      = imm_s;
				dec.is_store = 1'b1;
			end
			OP_JAL: begin
				// link value rides through the alu
				dec.alu_op = ALU_PASSB;
				dec.opb    = pc_q + 32'd4;
				dec.rd_wen = 1'b1;
			end
			OP_SYSTEM: begin
				dec.is_halt = 1'b1;
			end
			default: begin
				dec.rd_wen = 1'b0;
			end
		endcase
		dec.rd_wen = dec.rd_wen & (inst_q.r_view.rd != 5'd0);
	end

	assign out.valid   = valid_q & ~stall;
	assign out.pc      = pc_q;
	assign out.payload = dec;

	assign fire    = out.valid & out.allowin;
	assign flush_o = fire & taken;

	// nothing new enters behind a redirect or an ebreak
	assign in.allowin = ~halted_q & ~flush_o & ~(fire & dec.is_halt) & (~valid_q | fire);
	assign in_fire    = in.valid & in.allowin;

	always_ff @(posedge clock) begin
		if (rst_i) begin
			valid_q  <= 1'b0;
			halted_q <= 1'b0;
		end else begin
			if (in_fire) begin
				valid_q <= 1'b1;
			end else if (fire) begin
				valid_q <= 1'b0;
			end
			if (fire & dec.is_halt) begin
				halted_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (in_fire) begin
			inst_q <= in.payload;
			pc_q   <= in.pc;
		end
	end

endmodule

// File: rtl/ifu_stage.sv
module ifu_stage (
	input  logic                      clock,
	input  logic                      rst_i,
	input  logic                      flush_i,
	input  logic [core_pkg::XLEN-1:0] flush_pc_i,
	input  logic                      inst_pvalid_i,
	input  logic [core_pkg::XLEN-1:0] inst_prdata_i,
	output logic                      inst_psel_o,
	output logic [core_pkg::XLEN-1:0] inst_paddr_o,
	stage_if.up                       out
);
	import core_pkg::*;

	logic [XLEN-1:0] pc_q;
	logic [XLEN-1:0] addr_q;
	logic            req_q;
	logic            drop_q;
	logic            buf_valid_q;
	inst_u           buf_inst_q;
	logic [XLEN-1:0] buf_pc_q;
	logic            fire;
	logic            resp_keep;
	logic            issue;

	assign fire = buf_valid_q & out.allowin;
	// wrong-path responses are swallowed
	assign resp_keep = req_q & inst_pvalid_i & ~drop_q & ~flush_i;
	// one instruction in flight or buffered at most
	assign issue = ~req_q & ~flush_i & (~buf_valid_q | fire);

	always_ff @(posedge clock) begin
		if (rst_i) begin
			pc_q        <= RESET_PC;
			req_q       <= 1'b0;
			drop_q      <= 1'b0;
			buf_valid_q <= 1'b0;
		end else begin
			if (flush_i) begin
				pc_q <= flush_pc_i;
			end else if (resp_keep) begin
				pc_q <= addr_q + 32'd4;
			end

			if (flush_i) begin
				buf_valid_q <= 1'b0;
			end else if (resp_keep) begin
				buf_valid_q <= 1'b1;
			end else if (fire) begin
				buf_valid_q <= 1'b0;
			end

			if (req_q) begin
				if (inst_pvalid_i) begin
					req_q  <= 1'b0;
					drop_q <= 1'b0;
				end else if (flush_i) begin
					drop_q <= 1'b1;
				end
			end else if (issue) begin
				req_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (issue) begin
			addr_q <= pc_q;
		end
		if (resp_keep) begin
			buf_inst_q <= inst_prdata_i;
			buf_pc_q   <= addr_q;
		end
	end

	assign inst_psel_o  = req_q;
	assign inst_paddr_o = addr_q;

	assign out.valid   = buf_valid_q;
	assign out.pc      = buf_pc_q;
	assign out.payload = buf_inst_q;

endmodule

// File: rtl/lsu_stage.sv
module lsu_stage (
	input  logic                      clock,
	input  logic                      rst_i,
	input  logic [core_pkg::XLEN-1:0] data_prdata_i,
	input  logic                      data_pvalid_i,
	output logic                      data_psel_o,
	output logic                      data_pwrite_o,
	output logic [core_pkg::XLEN-1:0] data_paddr_o,
	output logic [core_pkg::XLEN-1:0] data_pwdata_o,
	output logic [3:0]                data_pwstrb_o,
	output logic [4:0]                rd_o,
	output logic                      wen_o,
	output logic                      reg_wen_o,
	output logic [4:0]                reg_waddr_o,
	output logic [core_pkg::XLEN-1:0] reg_wdata_o,
	output logic                      halt_o,
	stage_if.down                     in
);
	import core_pkg::*;

	logic   mem_q;
	ex_ls_t ls_q;
	logic   in_fire;
	logic   in_mem;
	logic   load_done;

	// one write port, so nothing is taken while an access is open
	assign in.allowin = ~mem_q;
	assign in_fire    = in.valid & in.allowin;
	assign in_mem     = in.payload.is_load | in.payload.is_store;
	assign load_done  = mem_q & data_pvalid_i & ls_q.is_load;

	always_ff @(posedge clock) begin
		if (rst_i) begin
			mem_q  <= 1'b0;
			halt_o <= 1'b0;
		end else begin
			if (in_fire & in_mem) begin
				mem_q <= 1'b1;
			end else if (data_pvalid_i) begin
				mem_q <= 1'b0;
			end
			if (in_fire & in.payload.is_halt) begin
				halt_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (in_fire & in_mem) begin
			ls_q <= in.payload;
		end
	end

	assign data_psel_o   = mem_q;
	assign data_pwrite_o = ls_q.is_store;
	assign data_paddr_o  = ls_q.result;
	assign data_pwdata_o = ls_q.store_data;
	assign data_pwstrb_o = {4{ls_q.is_store}};

	// alu results retire on acceptance, loads on the data pulse
	assign reg_wen_o   = load_done ? ls_q.rd_wen :
		(in_fire & ~in_mem & in.payload.rd_wen);
	assign reg_waddr_o = mem_q ? ls_q.rd : in.payload.rd;
	assign reg_wdata_o = mem_q ? data_prdata_i : in.payload.result;

	assign rd_o  = ls_q.rd;
	assign wen_o = mem_q & ls_q.rd_wen;

endmodule

// File: rtl/regfile.sv
module regfile (
	input  logic                      clock,
	input  logic                      rst_i,
	input  logic [4:0]                raddr1_i,
	input  logic [4:0]                raddr2_i,
	input  logic                      wen_i,
	input  logic [4:0]                waddr_i,
	input  logic [core_pkg::XLEN-1:0] wdata_i,
	output logic [core_pkg::XLEN-1:0] rdata1_o,
	output logic [core_pkg::XLEN-1:0] rdata2_o
);
	import core_pkg::*;

	// x0 has no storage
	logic [XLEN-1:0] regs [1:31];

	always_ff @(posedge clock) begin
		if (rst_i) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen_i && waddr_i != 5'd0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	assign rdata1_o = (raddr1_i == 5'd0) ? '0 : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == 5'd0) ? '0 : regs[raddr2_i];

endmodule

// File: rtl/stage_if.sv
interface stage_if #(
	parameter type payload_t = core_pkg::inst_u
) ();
	import core_pkg::*;

	// upstream drives valid, pc and payload
	logic            valid;
	logic [XLEN-1:0] pc;
	payload_t        payload;
	// downstream can take an item this cycle
	logic            allowin;

	modport up (
		output valid,
		output pc,
		output payload,
		input  allowin
	);

	modport down (
		input  valid,
		input  pc,
		input  payload,
		output allowin
	);

endinterface

// File: verification/core_tb.sv
module core_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import core_pkg::*;

	localparam int NUM_TESTS = 8;
	localparam int BODY_LEN = 48;
	// body, one dump store per register, ebreak
	localparam int PROG_LEN = BODY_LEN + 33;
	localparam int WATCHDOG_NS = 8 * 60 * NUM_TESTS * PROG_LEN;
	localparam int DUMP_BASE = 'h400;
	localparam logic [31:0] EBREAK = 32'h0010_0073;

	logic        clock;
	logic        rst_i;
	logic        inst_pvalid_i;
	logic [31:0] inst_prdata_i;
	logic        inst_psel_o;
	logic [31:0] inst_paddr_o;
	logic [31:0] data_prdata_i;
	logic        data_pvalid_i;
	logic        data_psel_o;
	logic        data_pwrite_o;
	logic [31:0] data_paddr_o;
	logic [31:0] data_pwdata_o;
	logic [3:0]  data_pwstrb_o;
	logic        halt_o;

	logic [31:0] prog [$];
	logic [31:0] dmem [logic [31:0]];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	int          test_errors;
	int          stores_seen;
	int          passed;
	int          failed;

	core_top dut0 (
		.clock         (clock),
		.rst_i         (rst_i),
		.inst_pvalid_i (inst_pvalid_i),
		.inst_prdata_i (inst_prdata_i),
		.inst_psel_o   (inst_psel_o),
		.inst_paddr_o  (inst_paddr_o),
		.data_prdata_i (data_prdata_i),
		.data_pvalid_i (data_pvalid_i),
		.data_psel_o   (data_psel_o),
		.data_pwrite_o (data_pwrite_o),
		.data_paddr_o  (data_paddr_o),
		.data_pwdata_o (data_pwdata_o),
		.data_pwstrb_o (data_pwstrb_o),
		.halt_o        (halt_o)
	);

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("Error: %s expected %h got %h", name, exp, act);
			test_errors++;
		end
	endtask

	function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
			logic [4:0] rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2);
		return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], OP_STORE};
	endfunction

	function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
			logic is_bne);
		return {off[12], off[10:5], rs2, rs1, 2'b00, is_bne, off[4:1], off[11], OP_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(logic [20:0] off, logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
	endfunction

	function automatic logic [2:0] random_funct3(input bit with_slt);
		logic [2:0] codes [5];
		codes = '{3'b000, 3'b100, 3'b110, 3'b111, 3'b010};
		return codes[$urandom_range(0, with_slt ? 4 : 3)];
	endfunction

	// anything past the program reads as ebreak
	function automatic logic [31:0] fetch_word(input logic [31:0] addr);
		int idx;
		idx = int'(addr >> 2);
		if (addr[1:0] == 2'b00 && idx < prog.size()) begin
			return prog[idx];
		end
		return EBREAK;
	endfunction

	task automatic gen_program();
		int          i;
		int          d;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] off;
		logic [2:0]  f3;
		prog.delete();
		i = 0;
		while (i < BODY_LEN) begin
			// few registers, so dependencies are dense
			rd = 5'($urandom_range(0, 7));
			rs1 = 5'($urandom_range(0, 7));
			rs2 = 5'($urandom_range(0, 7));
			off = 12'h100 + 12'($urandom_range(0, 15) * 4);
			// forward targets only, never past the register dump
			d = $urandom_range(1, 4);
			if (i + d > BODY_LEN) begin
				d = BODY_LEN - i;
			end
			case ($urandom_range(0, 9))
				0, 1: begin
					f3 = random_funct3(1'b1);
					prog.push_back({(f3 == 3'b000 && $urandom_range(0, 1)) ? 7'h20 : 7'h00,
						rs2, rs1, f3, rd, OP_OP});
				end
				4: prog.push_back({20'($urandom), rd, OP_LUI});
				5: begin
					prog.push_back(enc_s(off, rs2));
					if (i + 1 < BODY_LEN && $urandom_range(0, 1)) begin
						prog.push_back(enc_i(off, 5'd0, 3'b010, rd, OP_LOAD));
						i++;
					end
				end
				6: prog.push_back(enc_i(off, 5'd0, 3'b010, rd, OP_LOAD));
				7: prog.push_back(enc_b(13'(d * 4), rs2, rs1, 1'($urandom_range(0, 1))));
				8: prog.push_back(enc_j(21'(d * 4), rd));
				default: prog.push_back(enc_i(12'($urandom), rs1, random_funct3(1'b0), rd, OP_IMM));
			endcase
			i++;
		end
		for (int r = 0; r < 32; r++) begin
			prog.push_back(enc_s(12'(DUMP_BASE + 4 * r), 5'(r)));
		end
		prog.push_back(EBREAK);
	endtask

	// instruction set model, gives the expected store sequence
	task automatic run_model();
		logic [31:0] x [32];
		logic [31:0] mem [logic [31:0]];
		logic [31:0] pc;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] addr;
		logic [31:0] res;
		logic [31:0] next;
		logic        wb;
		logic        done;
		foreach (x[k]) begin
			x[k] = '0;
		end
		exp_addr.delete();
		exp_data.delete();
		pc = RESET_PC;
		done = 1'b0;
		while (!done) begin
			w = fetch_word(pc);
			a = x[w[19:15]];
			b = x[w[24:20]];
			imm_i = {{20{w[31]}}, w[31:20]};
			res = '0;
			wb = 1'b0;
			next = pc + 32'd4;
			case (w[6:0])
				OP_OP, OP_IMM: begin
					wb = 1'b1;
					if (w[6:0] == OP_IMM) begin
						b = imm_i;
					end
					case (w[14:12])
						3'b000: res = (w[6:0] == OP_OP && w[30]) ? a - b : a + b;
						3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						3'b100: res = a ^ b;
						3'b110: res = a | b;
						default: res = a & b;
					endcase
				end
				OP_LUI: begin
					wb = 1'b1;
					res = {w[31:12], 12'd0};
				end
				OP_LOAD: begin
					wb = 1'b1;
					addr = a + imm_i;
					res = mem.exists(addr) ? mem[addr] : '0;
				end
				OP_STORE: begin
					addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
					mem[addr] = b;
					exp_addr.push_back(addr);
					exp_data.push_back(b);
				end
				OP_BRANCH: begin
					if ((a == b) != w[12]) begin
						next = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
					end
				end
				OP_JAL: begin
					wb = 1'b1;
					res = pc + 32'd4;
					next = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
				end
				default: done = 1'b1;
			endcase
			if (wb && w[11:7] != 5'd0) begin
				x[w[11:7]] = res;
			end
			pc = next;
		end
	endtask

	task automatic run_test(input int num);
		@(posedge clock);
		#1;
		rst_i = 1'b1;
		test_errors = 0;
		stores_seen = 0;
		gen_program();
		run_model();
		dmem.delete();
		repeat (8) @(posedge clock);
		#1;
		check_val("inst_psel_o", 32'd0, inst_psel_o);
		check_val("data_psel_o", 32'd0, data_psel_o);
		check_val("halt_o", 32'd0, halt_o);
		rst_i = 1'b0;
		while (halt_o !== 1'b1) begin
			@(posedge clock);
			#1;
		end
		// a stray access after ebreak would show up here
		repeat (20) @(posedge clock);
		#1;
		if (exp_addr.size() != 0) begin
			$display("test %0d: %0d stores of the model never reached the data port",
				num, exp_addr.size());
			test_errors++;
		end
		if (test_errors == 0) begin
			passed++;
		end else begin
			failed++;
		end
		$display("test %0d: %0d instructions, %0d stores checked, %0d errors",
			num, prog.size(), stores_seen, test_errors);
	endtask

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	initial begin
		inst_pvalid_i = 1'b0;
		inst_prdata_i = '0;
		forever begin
			@(posedge clock);
			#1;
			inst_pvalid_i = 1'b0;
			if (!rst_i && inst_psel_o) begin
				repeat ($urandom_range(0, 3)) begin
					@(posedge clock);
					#1;
				end
				inst_prdata_i = fetch_word(inst_paddr_o);
				inst_pvalid_i = 1'b1;
			end
		end
	end

	initial begin
		data_pvalid_i = 1'b0;
		data_prdata_i = '0;
		forever begin
			@(posedge clock);
			#1;
			data_pvalid_i = 1'b0;
			if (!rst_i && data_psel_o) begin
				if (halt_o) begin
					$display("data access to %h after ebreak completed", data_paddr_o);
					test_errors++;
				end
				repeat ($urandom_range(0, 3)) begin
					@(posedge clock);
					#1;
				end
				if (data_pwrite_o) begin
					stores_seen++;
					check_val("data_pwstrb_o", 32'hf, data_pwstrb_o);
					if (exp_addr.size() == 0) begin
						$display("store to %h that the model never made", data_paddr_o);
						test_errors++;
					end else begin
						check_val("data_paddr_o", exp_addr.pop_front(), data_paddr_o);
						check_val("data_pwdata_o", exp_data.pop_front(), data_pwdata_o);
					end
					dmem[data_paddr_o] = data_pwdata_o;
				end else begin
					check_val("data_pwstrb_o", 32'h0, data_pwstrb_o);
					data_prdata_i = dmem.exists(data_paddr_o) ? dmem[data_paddr_o] : '0;
				end
				data_pvalid_i = 1'b1;
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		rst_i = 1'b1;
		passed = 0;
		failed = 0;
		void'($urandom(50));
		for (int t = 0; t < NUM_TESTS; t++) begin
			run_test(t);
		end
		$display("%0d tests passed, %0d tests failed", passed, failed);
		if (failed == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule
